/* core_pkg.sv */
/*
 * MIPS core shared definitions
 * Widths, reset vector, instruction field encodings, ALU operations
 * and the records passed between pipeline stages
 */
`default_nettype none

package core_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 2 ** REG_AW;

    localparam logic [DATA_W-1:0] RESET_PC = 32'hBFC0_0000;

    // --------------------------------------------------
    // Instruction encodings
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // --------------------------------------------------
    // Stage records
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] pc;
        alu_op_e           alu_op;
        logic [DATA_W-1:0] opr1;
        logic [DATA_W-1:0] opr2;
        logic [4:0]        shamt;
        logic              wreg;
        logic [REG_AW-1:0] wraddr;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] pc;
        logic [REG_AW-1:0] wraddr;
        logic [DATA_W-1:0] wrdata;
    } ex_wb_t;

endpackage

`default_nettype wire

/* fetch_unit.sv */
/*
 * Instruction fetch
 * Program counter and Wishbone classic read master; each acked word
 * is handed to decode as a one-cycle valid record
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                          clk,
    input  wire                          reset_i,
    output logic                         ibus_cyc_o,
    output logic                         ibus_stb_o,
    output logic [core_pkg::DATA_W-1:0]  ibus_adr_o,
    input  wire  [core_pkg::DATA_W-1:0]  ibus_dat_i,
    input  wire                          ibus_ack_i,
    output core_pkg::fetch_t             fetch_o
);

    logic                        idle_q;
    logic [core_pkg::DATA_W-1:0] pc_q;
    logic                        take;

    // Bus drops for one cycle after every ack
    assign ibus_cyc_o = ~idle_q;
    assign ibus_stb_o = ~idle_q;
    assign ibus_adr_o = pc_q;
    assign take       = ibus_stb_o & ibus_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            idle_q <= 1'b1;
            pc_q   <= core_pkg::RESET_PC;
        end else begin
            idle_q <= take;
            if (take) begin
                pc_q <= pc_q + core_pkg::DATA_W'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= take;
        end
        if (take) begin
            fetch_o.pc    <= pc_q;
            fetch_o.instr <= ibus_dat_i;
        end
    end

    // --------------------------------------------------
    // Wishbone classic master rules
    a_stb_cyc: assert property (@(posedge clk) disable iff (reset_i)
        ibus_stb_o |-> ibus_cyc_o);

    a_adr_hold: assert property (@(posedge clk) disable iff (reset_i)
        ibus_stb_o && !ibus_ack_i |=> ibus_stb_o && $stable(ibus_adr_o));

endmodule

`default_nettype wire

/* decode_stage.sv */
/*
 * Decode stage
 * Maps opcode and function fields to ALU operations, picks operands
 * with forwarding from execute and retire, and registers the result
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire  core_pkg::fetch_t       fetch_i,
    output logic [core_pkg::REG_AW-1:0]  rs_addr_o,
    output logic [core_pkg::REG_AW-1:0]  rt_addr_o,
    input  wire  [core_pkg::DATA_W-1:0]  rs_data_i,
    input  wire  [core_pkg::DATA_W-1:0]  rt_data_i,
    input  wire  core_pkg::ex_wb_t       ex_fwd_i,
    input  wire  core_pkg::ex_wb_t       wb_fwd_i,
    output core_pkg::id_ex_t             id_ex_o
);

    core_pkg::opcode_e           opcode;
    core_pkg::funct_e            funct;
    core_pkg::alu_op_e           alu_op;
    logic [core_pkg::DATA_W-1:0] imm_sext;
    logic [core_pkg::DATA_W-1:0] imm_zext;
    logic [core_pkg::DATA_W-1:0] rs_val;
    logic [core_pkg::DATA_W-1:0] rt_val;
    logic [core_pkg::DATA_W-1:0] opr2;
    logic                        wreg;
    logic                        use_rd;

    // Newest producer wins, register 0 is hardwired
    function automatic logic [core_pkg::DATA_W-1:0] forward(
        input logic [core_pkg::REG_AW-1:0] addr,
        input logic [core_pkg::DATA_W-1:0] rf_data
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd_i.valid && ex_fwd_i.wraddr == addr) begin
            return ex_fwd_i.wrdata;
        end else if (wb_fwd_i.valid && wb_fwd_i.wraddr == addr) begin
            return wb_fwd_i.wrdata;
        end
        return rf_data;
    endfunction

    assign opcode    = core_pkg::opcode_e'(fetch_i.instr[31:26]);
    assign funct     = core_pkg::funct_e'(fetch_i.instr[5:0]);
    assign rs_addr_o = fetch_i.instr[25:21];
    assign rt_addr_o = fetch_i.instr[20:16];
    assign imm_sext  = {{16{fetch_i.instr[15]}}, fetch_i.instr[15:0]};
    assign imm_zext  = {16'h0000, fetch_i.instr[15:0]};
    assign rs_val    = forward(rs_addr_o, rs_data_i);
    assign rt_val    = forward(rt_addr_o, rt_data_i);

    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        opr2   = rt_val;
        wreg   = 1'b1;
        use_rd = 1'b0;
        case (opcode)
            core_pkg::OP_SPECIAL: begin
                use_rd = 1'b1;
                case (funct)
                    core_pkg::FN_ADDU: alu_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: alu_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  alu_op = core_pkg::ALU_XOR;
                    core_pkg::FN_NOR:  alu_op = core_pkg::ALU_NOR;
                    core_pkg::FN_SLT:  alu_op = core_pkg::ALU_SLT;
                    core_pkg::FN_SLTU: alu_op = core_pkg::ALU_SLTU;
                    core_pkg::FN_SLL:  alu_op = core_pkg::ALU_SLL;
                    core_pkg::FN_SRL:  alu_op = core_pkg::ALU_SRL;
                    core_pkg::FN_SRA:  alu_op = core_pkg::ALU_SRA;
                    default:           wreg   = 1'b0;
                endcase
            end
            core_pkg::OP_ADDIU: opr2 = imm_sext;
            core_pkg::OP_SLTI: begin
                alu_op = core_pkg::ALU_SLT;
                opr2   = imm_sext;
            end
            core_pkg::OP_SLTIU: begin
                alu_op = core_pkg::ALU_SLTU;
                opr2   = imm_sext;
            end
            core_pkg::OP_ANDI: begin
                alu_op = core_pkg::ALU_AND;
                opr2   = imm_zext;
            end
            core_pkg::OP_ORI: begin
                alu_op = core_pkg::ALU_OR;
                opr2   = imm_zext;
            end
            core_pkg::OP_XORI: begin
                alu_op = core_pkg::ALU_XOR;
                opr2   = imm_zext;
            end
            core_pkg::OP_LUI: begin
                alu_op = core_pkg::ALU_LUI;
                opr2   = imm_zext;
            end
            // Anything else passes through as a no-op
            default: wreg = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o.valid <= fetch_i.valid;
        end
        if (fetch_i.valid) begin
            id_ex_o.pc     <= fetch_i.pc;
            id_ex_o.alu_op <= alu_op;
            id_ex_o.opr1   <= rs_val;
            id_ex_o.opr2   <= opr2;
            id_ex_o.shamt  <= fetch_i.instr[10:6];
            id_ex_o.wreg   <= wreg;
            id_ex_o.wraddr <= use_rd ? fetch_i.instr[15:11] : fetch_i.instr[20:16];
        end
    end

    a_known_op: assert property (@(posedge clk) disable iff (reset_i)
        id_ex_o.valid && id_ex_o.wreg |->
            !$isunknown(id_ex_o.alu_op) && id_ex_o.alu_op <= core_pkg::ALU_LUI);

endmodule

`default_nettype wire

/* reg_file.sv */
/*
 * Register file
 * 32 x 32-bit, two asynchronous read ports and one write port fed
 * by the retire record
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire  [core_pkg::REG_AW-1:0]  rs_addr_i,
    input  wire  [core_pkg::REG_AW-1:0]  rt_addr_i,
    output logic [core_pkg::DATA_W-1:0]  rs_data_o,
    output logic [core_pkg::DATA_W-1:0]  rt_data_o,
    input  wire  core_pkg::ex_wb_t       wr_i
);

    logic [core_pkg::DATA_W-1:0] regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid) begin
            regs[wr_i.wraddr] <= wr_i.wrdata;
        end
    end

    // r0 is hardwired
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

    // Execute filters r0 writes before they retire
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        wr_i.valid |-> wr_i.wraddr != '0);

endmodule

`default_nettype wire

/* alu_execute.sv */
/*
 * Execute stage
 * ALU and the execute-to-retire result register; the unregistered
 * result is also offered to decode for forwarding
 */
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire  core_pkg::id_ex_t  id_ex_i,
    output core_pkg::ex_wb_t    ex_fwd_o,
    output core_pkg::ex_wb_t    ex_wb_o
);

    logic [core_pkg::DATA_W-1:0] opr1;
    logic [core_pkg::DATA_W-1:0] opr2;
    logic [core_pkg::DATA_W-1:0] result;
    logic                        slt;
    logic                        sltu;

    assign opr1 = id_ex_i.opr1;
    assign opr2 = id_ex_i.opr2;
    assign slt  = $signed(opr1) < $signed(opr2);
    assign sltu = opr1 < opr2;

    always_comb begin
        case (id_ex_i.alu_op)
            core_pkg::ALU_ADD:  result = opr1 + opr2;
            core_pkg::ALU_SUB:  result = opr1 - opr2;
            core_pkg::ALU_AND:  result = opr1 & opr2;
            core_pkg::ALU_OR:   result = opr1 | opr2;
            core_pkg::ALU_XOR:  result = opr1 ^ opr2;
            core_pkg::ALU_NOR:  result = ~(opr1 | opr2);
            core_pkg::ALU_SLT:  result = {{(core_pkg::DATA_W-1){1'b0}}, slt};
            core_pkg::ALU_SLTU: result = {{(core_pkg::DATA_W-1){1'b0}}, sltu};
            core_pkg::ALU_SLL:  result = opr2 << id_ex_i.shamt;
            core_pkg::ALU_SRL:  result = opr2 >> id_ex_i.shamt;
            core_pkg::ALU_SRA:  result = $unsigned($signed(opr2) >>> id_ex_i.shamt);
            core_pkg::ALU_LUI:  result = {opr2[15:0], 16'h0000};
            default:            result = '0;
        endcase
    end

    // --------------------------------------------------
    // Only writes to a nonzero register retire
    always_comb begin
        ex_fwd_o.valid  = id_ex_i.valid && id_ex_i.wreg && (id_ex_i.wraddr != '0);
        ex_fwd_o.pc     = id_ex_i.pc;
        ex_fwd_o.wraddr = id_ex_i.wraddr;
        ex_fwd_o.wrdata = result;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_wb_o.valid <= 1'b0;
        end else begin
            ex_wb_o.valid <= ex_fwd_o.valid;
        end
        if (ex_fwd_o.valid) begin
            ex_wb_o.pc     <= ex_fwd_o.pc;
            ex_wb_o.wraddr <= ex_fwd_o.wraddr;
            ex_wb_o.wrdata <= ex_fwd_o.wrdata;
        end
    end

endmodule

`default_nettype wire

/* mips_core_top.sv */
/*
 * MIPS integer core top level
 * Fetch, decode, register file and execute, with a Wishbone
 * instruction port and the retire trace
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core_top (
    input  wire                          clk,
    input  wire                          reset_i,

    output logic                         ibus_cyc_o,
    output logic                         ibus_stb_o,
    output logic [core_pkg::DATA_W-1:0]  ibus_adr_o,
    input  wire  [core_pkg::DATA_W-1:0]  ibus_dat_i,
    input  wire                          ibus_ack_i,

    output logic                         debug_wb_valid_o,
    output logic [core_pkg::DATA_W-1:0]  debug_wb_pc_o,
    output logic [core_pkg::REG_AW-1:0]  debug_wb_wraddr_o,
    output logic [core_pkg::DATA_W-1:0]  debug_wb_wrdata_o
);

    core_pkg::fetch_t            if_id;
    core_pkg::id_ex_t            id_ex;
    core_pkg::ex_wb_t            ex_fwd;
    core_pkg::ex_wb_t            ex_wb;
    logic [core_pkg::REG_AW-1:0] rs_addr;
    logic [core_pkg::REG_AW-1:0] rt_addr;
    logic [core_pkg::DATA_W-1:0] rs_data;
    logic [core_pkg::DATA_W-1:0] rt_data;

    fetch_unit fetch (
        .clk        (clk        ),
        .reset_i    (reset_i    ),
        .ibus_cyc_o (ibus_cyc_o ),
        .ibus_stb_o (ibus_stb_o ),
        .ibus_adr_o (ibus_adr_o ),
        .ibus_dat_i (ibus_dat_i ),
        .ibus_ack_i (ibus_ack_i ),
        .fetch_o    (if_id      )
    );

    decode_stage decode (
        .clk        (clk        ),
        .reset_i    (reset_i    ),
        .fetch_i    (if_id      ),
        .rs_addr_o  (rs_addr    ),
        .rt_addr_o  (rt_addr    ),
        .rs_data_i  (rs_data    ),
        .rt_data_i  (rt_data    ),
        .ex_fwd_i   (ex_fwd     ),
        .wb_fwd_i   (ex_wb      ),
        .id_ex_o    (id_ex      )
    );

    reg_file regfile (
        .clk        (clk        ),
        .reset_i    (reset_i    ),
        .rs_addr_i  (rs_addr    ),
        .rt_addr_i  (rt_addr    ),
        .rs_data_o  (rs_data    ),
        .rt_data_o  (rt_data    ),
        .wr_i       (ex_wb      )
    );

    alu_execute alu_ex (
        .clk        (clk        ),
        .reset_i    (reset_i    ),
        .id_ex_i    (id_ex      ),
        .ex_fwd_o   (ex_fwd     ),
        .ex_wb_o    (ex_wb      )
    );

    // Retire trace
    assign debug_wb_valid_o  = ex_wb.valid;
    assign debug_wb_pc_o     = ex_wb.pc;
    assign debug_wb_wraddr_o = ex_wb.wraddr;
    assign debug_wb_wrdata_o = ex_wb.wrdata;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 20 ns clock, reset held high for the first five rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        reset_o <= 1'b0;
    end

    always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb_mips_core.sv */
/*
 * Testbench for the MIPS integer core
 * Random ALU program served by a Wishbone responder with wait states,
 * retire trace checked against a sequential reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int PROG_LEN   = 400;
    localparam int MAX_CYCLES = PROG_LEN * 7 + 100;
    localparam int DRAIN      = 10;
    localparam int T_RESET    = 0;
    localparam int T_FETCH    = 1;
    localparam int T_TRACE    = 2;
    localparam int T_TIMING   = 3;

    logic        clk;
    logic        reset_i;
    logic        ibus_cyc_o;
    logic        ibus_stb_o;
    logic [31:0] ibus_adr_o;
    logic [31:0] ibus_dat_i = 32'h0;
    logic        ibus_ack_i = 1'b0;
    logic        debug_wb_valid_o;
    logic [31:0] debug_wb_pc_o;
    logic [4:0]  debug_wb_wraddr_o;
    logic [31:0] debug_wb_wrdata_o;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    int          ack_cycle [logic [31:0]];

    int          cycle = 0;
    int          wait_left = 0;
    int          fetched = 0;
    int          post_reset = 0;
    int          noop_count = 0;
    logic [31:0] next_adr = core_pkg::RESET_PC;
    logic [31:0] req_adr = 32'h0;
    logic        req_open = 1'b0;
    int          checks [4] = '{0, 0, 0, 0};
    int          errors [4] = '{0, 0, 0, 0};

    tb_clock_gen clock_gen (
        .clk_o   (clk    ),
        .reset_o (reset_i)
    );

    mips_core_top i_dut (
        .clk               (clk              ),
        .reset_i           (reset_i          ),
        .ibus_cyc_o        (ibus_cyc_o       ),
        .ibus_stb_o        (ibus_stb_o       ),
        .ibus_adr_o        (ibus_adr_o       ),
        .ibus_dat_i        (ibus_dat_i       ),
        .ibus_ack_i        (ibus_ack_i       ),
        .debug_wb_valid_o  (debug_wb_valid_o ),
        .debug_wb_pc_o     (debug_wb_pc_o    ),
        .debug_wb_wraddr_o (debug_wb_wraddr_o),
        .debug_wb_wrdata_o (debug_wb_wrdata_o)
    );

    // --------------------------------------------------
    // Reporting
    task automatic report_mismatch(input int test, input string name,
                                   input logic [31:0] exp, input logic [31:0] got);
        errors[test]++;
        $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic report_problem(input int test, input string what);
        errors[test]++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic summarize_test(input int test, input string name);
        $display("Test %-14s %0d checks, %0d errors", name, checks[test], errors[test]);
    endtask

    // --------------------------------------------------
    // Program generation and reference model
    function automatic logic [31:0] gen_instr();
        int unsigned kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  code;
        if ($urandom_range(99, 0) >= 85) begin
            return $urandom;
        end
        rs   = 5'($urandom_range(5, 0));
        rt   = 5'($urandom_range(5, 0));
        rd   = 5'($urandom_range(5, 0));
        sh   = 5'($urandom_range(31, 0));
        imm  = 16'($urandom);
        kind = $urandom_range(17, 0);
        case (kind)
            0:  code = 6'h21;
            1:  code = 6'h23;
            2:  code = 6'h24;
            3:  code = 6'h25;
            4:  code = 6'h26;
            5:  code = 6'h27;
            6:  code = 6'h2A;
            7:  code = 6'h2B;
            8:  code = 6'h00;
            9:  code = 6'h02;
            10: code = 6'h03;
            11: code = 6'h09;
            12: code = 6'h0A;
            13: code = 6'h0B;
            14: code = 6'h0C;
            15: code = 6'h0D;
            16: code = 6'h0E;
            default: code = 6'h0F;
        endcase
        if (kind < 11) begin
            return {6'h00, rs, rt, rd, sh, code};
        end
        return {code, rs, rt, imm};
    endfunction

    // Executes one instruction in program order from the MIPS32 encodings
    task automatic model_step(
        input  logic [31:0] instr,
        output logic        wr,
        output logic [4:0]  dst,
        output logic [31:0] res
    );
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [4:0]  sh;
        a   = model_regs[instr[25:21]];
        b   = model_regs[instr[20:16]];
        se  = {{16{instr[15]}}, instr[15:0]};
        ze  = {16'h0000, instr[15:0]};
        sh  = instr[10:6];
        wr  = 1'b1;
        dst = instr[20:16];
        res = 32'h0;
        case (instr[31:26])
            6'h00: begin
                dst = instr[15:11];
                case (instr[5:0])
                    6'h00: res = b << sh;
                    6'h02: res = b >> sh;
                    6'h03: res = $signed(b) >>> sh;
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2A: res = {31'b0, $signed(a) < $signed(b)};
                    6'h2B: res = {31'b0, a < b};
                    default: wr = 1'b0;
                endcase
            end
            6'h09: res = a + se;
            6'h0A: res = {31'b0, $signed(a) < $signed(se)};
            6'h0B: res = {31'b0, a < se};
            6'h0C: res = a & ze;
            6'h0D: res = a | ze;
            6'h0E: res = a ^ ze;
            6'h0F: res = {instr[15:0], 16'h0000};
            default: wr = 1'b0;
        endcase
        if (dst == 5'd0) begin
            wr = 1'b0;
        end
        if (wr) begin
            model_regs[dst] = res;
        end
    endtask

    task automatic build_program();
        logic        wr;
        logic [4:0]  dst;
        logic [31:0] res;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = gen_instr();
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            model_step(prog[i], wr, dst, res);
            if (wr) begin
                exp_pc.push_back(core_pkg::RESET_PC + 32'(i * 4));
                exp_addr.push_back(dst);
                exp_data.push_back(res);
            end else begin
                noop_count++;
            end
        end
    endtask

    // Zero words past the program decode as SLL to r0
    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        logic [31:0] offset;
        int          idx;
        offset = adr - core_pkg::RESET_PC;
        idx    = int'(offset >> 2);
        if (offset[1:0] == 2'b00 && offset < 32'(PROG_LEN * 4)) begin
            return prog[idx];
        end
        return 32'h0;
    endfunction

    // --------------------------------------------------
    // Wishbone responder with 0 to 3 wait cycles
    always @(posedge clk) begin
        if (reset_i) begin
            ibus_ack_i <= 1'b0;
            wait_left  <= 0;
        end else if (ibus_stb_o && !ibus_ack_i) begin
            if (wait_left == 0) begin
                ibus_ack_i <= 1'b1;
                ibus_dat_i <= mem_word(ibus_adr_o);
            end else begin
                wait_left <= wait_left - 1;
            end
        end else begin
            ibus_ack_i <= 1'b0;
            wait_left  <= int'($urandom_range(3, 0));
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Monitors sample on the falling edge
    task automatic track_fetch();
        if (ibus_stb_o) begin
            checks[T_FETCH] += 2;
            if (ibus_cyc_o !== 1'b1) begin
                report_mismatch(T_FETCH, "ibus_cyc_o", 32'd1, 32'(ibus_cyc_o));
            end
            if (req_open) begin
                if (ibus_adr_o !== req_adr) begin
                    report_mismatch(T_FETCH, "ibus_adr_o", req_adr, ibus_adr_o);
                end
            end else begin
                if (ibus_adr_o !== next_adr) begin
                    report_mismatch(T_FETCH, "ibus_adr_o", next_adr, ibus_adr_o);
                end
                req_open = 1'b1;
                req_adr  = next_adr;
            end
            if (ibus_ack_i) begin
                // Edge that raised ack
                ack_cycle[ibus_adr_o] = cycle;
                next_adr = req_adr + 32'd4;
                req_open = 1'b0;
                fetched++;
            end
        end
    endtask

    task automatic track_retire();
        logic [31:0] pc;
        logic [4:0]  addr;
        logic [31:0] data;
        if (debug_wb_valid_o !== 1'b0) begin
            if (exp_pc.size() == 0) begin
                report_problem(T_TRACE, $sformatf("retire at pc %h with no model entry left",
                                                  debug_wb_pc_o));
            end else begin
                pc   = exp_pc.pop_front();
                addr = exp_addr.pop_front();
                data = exp_data.pop_front();
                checks[T_TRACE] += 3;
                if (debug_wb_pc_o !== pc) begin
                    report_mismatch(T_TRACE, "debug_wb_pc_o", pc, debug_wb_pc_o);
                end
                if (debug_wb_wraddr_o !== addr) begin
                    report_mismatch(T_TRACE, "debug_wb_wraddr_o", {27'b0, addr},
                                    {27'b0, debug_wb_wraddr_o});
                end
                if (debug_wb_wrdata_o !== data) begin
                    report_mismatch(T_TRACE, "debug_wb_wrdata_o", data, debug_wb_wrdata_o);
                end
            end
            checks[T_TIMING]++;
            if (!ack_cycle.exists(debug_wb_pc_o)) begin
                report_problem(T_TIMING, "retired pc was never acked on the bus");
            end else if (cycle != ack_cycle[debug_wb_pc_o] + 3) begin
                report_mismatch(T_TIMING, "debug_wb_valid_o edge",
                                32'(ack_cycle[debug_wb_pc_o] + 3), 32'(cycle));
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset_i) begin
            checks[T_RESET] += 3;
            if (ibus_cyc_o !== 1'b0) begin
                report_mismatch(T_RESET, "ibus_cyc_o", 32'd0, 32'(ibus_cyc_o));
            end
            if (ibus_stb_o !== 1'b0) begin
                report_mismatch(T_RESET, "ibus_stb_o", 32'd0, 32'(ibus_stb_o));
            end
            if (debug_wb_valid_o !== 1'b0) begin
                report_mismatch(T_RESET, "debug_wb_valid_o", 32'd0, 32'(debug_wb_valid_o));
            end
        end else begin
            post_reset++;
            if (post_reset == 1) begin
                checks[T_RESET] += 3;
                if (ibus_cyc_o !== 1'b0) begin
                    report_mismatch(T_RESET, "ibus_cyc_o", 32'd0, 32'(ibus_cyc_o));
                end
                if (ibus_stb_o !== 1'b0) begin
                    report_mismatch(T_RESET, "ibus_stb_o", 32'd0, 32'(ibus_stb_o));
                end
                if (debug_wb_valid_o !== 1'b0) begin
                    report_mismatch(T_RESET, "debug_wb_valid_o", 32'd0, 32'(debug_wb_valid_o));
                end
            end else if (post_reset == 2) begin
                checks[T_RESET] += 2;
                if (ibus_stb_o !== 1'b1) begin
                    report_mismatch(T_RESET, "ibus_stb_o", 32'd1, 32'(ibus_stb_o));
                end
                if (ibus_adr_o !== core_pkg::RESET_PC) begin
                    report_mismatch(T_RESET, "ibus_adr_o", core_pkg::RESET_PC, ibus_adr_o);
                end
                summarize_test(T_RESET, "reset_state");
            end
            track_fetch();
            track_retire();
        end
    end

    // --------------------------------------------------
    // Run control
    initial begin
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, %0d words fetched, %0d retires outstanding",
                 cycle, fetched, exp_pc.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errors;
        void'($urandom(98442));
        build_program();
        $display("Program of %0d words, %0d expected retires, %0d without trace",
                 PROG_LEN, exp_pc.size(), noop_count);
        while (!(fetched >= PROG_LEN && exp_pc.size() == 0)) begin
            @(posedge clk);
        end
        // Extra retires would show up here
        repeat (DRAIN) @(posedge clk);
        summarize_test(T_FETCH, "fetch_order");
        summarize_test(T_TRACE, "retire_values");
        summarize_test(T_TIMING, "retire_timing");
        total_checks = checks[0] + checks[1] + checks[2] + checks[3];
        total_errors = errors[0] + errors[1] + errors[2] + errors[3];
        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mango_lite.f */
core_pkg.sv
fetch_unit.sv
decode_stage.sv
reg_file.sv
alu_execute.sv
mips_core_top.sv
tb_clock_gen.sv
tb_mips_core.sv

/* Makefile */
TOP = tb_mips_core

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mango_lite.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --top-module mips_core_top \
		core_pkg.sv fetch_unit.sv decode_stage.sv reg_file.sv \
		alu_execute.sv mips_core_top.sv

clean:
	rm -rf obj_dir
